// ==== source/lc3b_defines.svh ====
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// width of a data word and of an instruction
`define LC3B_WORD_WIDTH 16

// general purpose registers R0 to R7
`define LC3B_NUM_REGS 8

// bits needed to name one register
`define LC3B_REG_WIDTH 3

`endif

// ==== source/lc3b_types.sv ====
`include "lc3b_defines.svh"

package lc3b_types;

	typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_word;
	typedef logic [`LC3B_REG_WIDTH-1:0] lc3b_reg;

	// opcode field, instruction bits 15 to 12
	typedef enum logic [3:0] {
		op_add  = 4'b0001,
		op_and  = 4'b0101,
		op_br   = 4'b0000,
		op_jmp  = 4'b1100,
		op_jsr  = 4'b0100,
		op_ldb  = 4'b0010,
		op_ldi  = 4'b1010,
		op_ldr  = 4'b0110,
		op_lea  = 4'b1110,
		op_not  = 4'b1001,
		op_rti  = 4'b1000,
		op_shf  = 4'b1101,
		op_stb  = 4'b0011,
		op_sti  = 4'b1011,
		op_str  = 4'b0111,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	// control carried down the pipe to execute, memory and writeback
	typedef struct packed {
		logic [1:0] alumux1_sel;
		logic [1:0] alumux2_sel;
		lc3b_aluop alu_ctrl;
		logic indirect;
		logic read;
		logic write;
		logic [1:0] mem_byte_sig;
		logic regfilemux_sel;
		logic load_regfile;
		logic memread_sel;
		logic load_cc;
		logic destmux_sel;
		logic [1:0] pcmux_sel;
		logic pcmux_sel_out_sel;
	} lc3b_ctrl_t;

	// selects used up inside decode and never registered
	typedef struct packed {
		logic sr1_sel;
		logic sr2_sel;
		logic sh6_sel;
		logic imm_sel;
	} lc3b_id_ctrl_t;

	typedef struct packed {
		logic valid;
		lc3b_word pc;
		lc3b_ctrl_t ctrl;
		lc3b_word sr1_data;
		lc3b_word sr2_data;
		lc3b_word imm_value;
		lc3b_reg dest;
		lc3b_opcode opcode;
	} lc3b_id_ex_t;

endpackage : lc3b_types

// ==== source/decode.sv ====
`timescale 1ns/10ps

module decode (
	input lc3b_types::lc3b_word instruction,
	output lc3b_types::lc3b_ctrl_t ctrl,
	output lc3b_types::lc3b_id_ctrl_t id_ctrl
);

	lc3b_types::lc3b_opcode opcode;

	assign opcode = lc3b_types::lc3b_opcode'(instruction[15:12]);

	// every field starts at zero, each opcode sets only what it needs
	always_comb begin
		ctrl = '0;
		ctrl.alu_ctrl = lc3b_types::alu_pass;
		id_ctrl = '0;
		case (opcode)
			lc3b_types::op_add: begin
				ctrl.alumux2_sel = instruction[5] ? 2'b11 : 2'b00;
				ctrl.alu_ctrl = lc3b_types::alu_add;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			lc3b_types::op_and: begin
				ctrl.alumux2_sel = instruction[5] ? 2'b11 : 2'b00;
				ctrl.alu_ctrl = lc3b_types::alu_and;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			lc3b_types::op_not: begin
				ctrl.alu_ctrl = lc3b_types::alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			lc3b_types::op_ldr: begin
				id_ctrl.sh6_sel = 1'b1;
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = lc3b_types::alu_add;
				ctrl.read = 1'b1;
				ctrl.mem_byte_sig = 2'b11;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.memread_sel = 1'b1;
			end
			lc3b_types::op_str: begin
				id_ctrl.sr2_sel = 1'b1;
				id_ctrl.sh6_sel = 1'b1;
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = lc3b_types::alu_add;
				ctrl.write = 1'b1;
				ctrl.mem_byte_sig = 2'b11;
			end
			lc3b_types::op_br: begin
				ctrl.alumux1_sel = 2'b01;
				ctrl.alumux2_sel = 2'b10;
				ctrl.alu_ctrl = lc3b_types::alu_add;
				ctrl.pcmux_sel_out_sel = 1'b1;
			end
			lc3b_types::op_jmp: begin
				ctrl.pcmux_sel = 2'b01;
			end
			lc3b_types::op_jsr: begin
				// bit 11 picks the PC relative form over JSRR
				if (instruction[11]) begin
					ctrl.alumux1_sel = 2'b10;
					ctrl.alumux2_sel = 2'b10;
					ctrl.alu_ctrl = lc3b_types::alu_add;
				end
				ctrl.destmux_sel = 1'b1;
				ctrl.regfilemux_sel = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.pcmux_sel = 2'b01;
			end
			lc3b_types::op_ldb: begin
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = lc3b_types::alu_add;
				ctrl.read = 1'b1;
				ctrl.mem_byte_sig = 2'b01;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.memread_sel = 1'b1;
			end
			lc3b_types::op_ldi: begin
				id_ctrl.sh6_sel = 1'b1;
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = lc3b_types::alu_add;
				ctrl.indirect = 1'b1;
				ctrl.read = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
				ctrl.memread_sel = 1'b1;
			end
			lc3b_types::op_lea: begin
				ctrl.alumux2_sel = 2'b10;
				ctrl.alu_ctrl = lc3b_types::alu_add;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			lc3b_types::op_shf: begin
				id_ctrl.imm_sel = 1'b1;
				// bit 4 is the direction, bit 5 asks for sign fill on a right shift
				if (!instruction[4])
					ctrl.alu_ctrl = lc3b_types::alu_sll;
				else if (!instruction[5])
					ctrl.alu_ctrl = lc3b_types::alu_srl;
				else
					ctrl.alu_ctrl = lc3b_types::alu_sra;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			lc3b_types::op_stb: begin
				id_ctrl.sr2_sel = 1'b1;
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = lc3b_types::alu_add;
				ctrl.write = 1'b1;
				ctrl.mem_byte_sig = 2'b01;
			end
			lc3b_types::op_sti: begin
				id_ctrl.sr2_sel = 1'b1;
				id_ctrl.sh6_sel = 1'b1;
				ctrl.alumux2_sel = 2'b01;
				ctrl.alu_ctrl = lc3b_types::alu_add;
				ctrl.indirect = 1'b1;
				ctrl.write = 1'b1;
			end
			lc3b_types::op_trap: begin
				ctrl.alumux1_sel = 2'b11;
				ctrl.destmux_sel = 1'b1;
				ctrl.regfilemux_sel = 1'b1;
				ctrl.load_regfile = 1'b1;
				ctrl.pcmux_sel = 2'b11;
			end
			default: begin
				// RTI and anything unused fall through as a no-op
			end
		endcase
	end

	always_comb begin
		assert final (!(ctrl.read && ctrl.write))
			else $error("decode: read and write both set for opcode %b", opcode);
	end

endmodule : decode

// ==== source/regfile.sv ====
`timescale 1ns/10ps
`include "lc3b_defines.svh"

module regfile (
	input logic clk,
	input logic reset,
	input logic wb_en,
	input lc3b_types::lc3b_reg wb_dest,
	input lc3b_types::lc3b_word wb_data,
	input lc3b_types::lc3b_reg sr1,
	input lc3b_types::lc3b_reg sr2,
	output lc3b_types::lc3b_word sr1_data,
	output lc3b_types::lc3b_word sr2_data
);

	lc3b_types::lc3b_word regs [`LC3B_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb_dest] <= wb_data;
		end
	end

	// writeback in the same cycle wins over the stored value
	always_comb begin
		if (wb_en && (wb_dest == sr1))
			sr1_data = wb_data;
		else
			sr1_data = regs[sr1];
		if (wb_en && (wb_dest == sr2))
			sr2_data = wb_data;
		else
			sr2_data = regs[sr2];
	end

	assert property (@(posedge clk) disable iff (reset) wb_en |-> !$isunknown(wb_dest))
		else $error("regfile: write enabled with unknown destination");

endmodule : regfile

// ==== source/operand_select.sv ====
`timescale 1ns/10ps

module operand_select (
	input lc3b_types::lc3b_word instruction,
	input lc3b_types::lc3b_ctrl_t ctrl,
	input lc3b_types::lc3b_id_ctrl_t id_ctrl,
	output lc3b_types::lc3b_reg sr1,
	output lc3b_types::lc3b_reg sr2,
	output lc3b_types::lc3b_reg dest,
	output lc3b_types::lc3b_word imm_value
);

	lc3b_types::lc3b_word offset6;
	lc3b_types::lc3b_word offset9;
	lc3b_types::lc3b_word offset11;
	lc3b_types::lc3b_word imm5;
	lc3b_types::lc3b_word imm4;
	lc3b_types::lc3b_word trapvect8;

	assign sr1 = instruction[8:6];

	// stores read the value to write from the DR field
	assign sr2 = id_ctrl.sr2_sel ? instruction[11:9] : instruction[2:0];

	// JSR and TRAP link through R7
	assign dest = ctrl.destmux_sel ? lc3b_types::lc3b_reg'(7) : instruction[11:9];

	// a size cast of a signed field sign extends it
	assign offset6 = lc3b_types::lc3b_word'($signed(instruction[5:0]));
	assign offset9 = lc3b_types::lc3b_word'($signed(instruction[8:0]));
	assign offset11 = lc3b_types::lc3b_word'($signed(instruction[10:0]));
	assign imm5 = lc3b_types::lc3b_word'($signed(instruction[4:0]));
	assign imm4 = lc3b_types::lc3b_word'(instruction[3:0]);
	assign trapvect8 = lc3b_types::lc3b_word'(instruction[7:0]);

	always_comb begin
		case (ctrl.alumux2_sel)
			2'b01: begin
				// word accesses scale the offset, byte accesses do not
				if (id_ctrl.sh6_sel)
					imm_value = offset6 << 1;
				else
					imm_value = offset6;
			end
			2'b10: begin
				if (ctrl.alumux1_sel == 2'b10)
					imm_value = offset11 << 1;
				else
					imm_value = offset9 << 1;
			end
			2'b11: imm_value = imm5;
			default: begin
				if (id_ctrl.imm_sel)
					imm_value = imm4;
				else if (ctrl.alumux1_sel == 2'b11)
					imm_value = trapvect8 << 1;
				else
					imm_value = '0;
			end
		endcase
	end

endmodule : operand_select

// ==== source/id_ex_register.sv ====
`timescale 1ns/10ps

module id_ex_register (
	input logic clk,
	input logic reset,
	input logic stall,
	input lc3b_types::lc3b_id_ex_t next,
	output lc3b_types::lc3b_id_ex_t id_ex
);

	// a bubble arrives as a bundle with valid low, it needs no special case here
	always_ff @(posedge clk) begin
		if (reset)
			id_ex <= '0;
		else if (!stall)
			id_ex <= next;
	end

	// execute may sample the held bundle again on the cycle after a stall
	assert property (@(posedge clk) disable iff (reset) stall |=> $stable(id_ex))
		else $error("id_ex_register: bundle changed while stalled");

endmodule : id_ex_register

// ==== source/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input lc3b_types::lc3b_word instruction,
	input lc3b_types::lc3b_word pc,
	input logic stall,
	input logic wb_en,
	input lc3b_types::lc3b_reg wb_dest,
	input lc3b_types::lc3b_word wb_data,
	output logic ready,
	output lc3b_types::lc3b_id_ex_t id_ex
);

	lc3b_types::lc3b_ctrl_t ctrl;
	lc3b_types::lc3b_id_ctrl_t id_ctrl;
	lc3b_types::lc3b_reg sr1;
	lc3b_types::lc3b_reg sr2;
	lc3b_types::lc3b_reg dest;
	lc3b_types::lc3b_word imm_value;
	lc3b_types::lc3b_word sr1_data;
	lc3b_types::lc3b_word sr2_data;
	lc3b_types::lc3b_id_ex_t next;

	// the stage is a single slot, so it can take a new instruction whenever execute moves
	assign ready = ~stall;

	decode decode_inst (
		.instruction(instruction),
		.ctrl(ctrl),
		.id_ctrl(id_ctrl)
	);

	operand_select operand_select_inst (
		.instruction(instruction),
		.ctrl(ctrl),
		.id_ctrl(id_ctrl),
		.sr1(sr1),
		.sr2(sr2),
		.dest(dest),
		.imm_value(imm_value)
	);

	regfile regfile_inst (
		.clk(clk),
		.reset(reset),
		.wb_en(wb_en),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.sr1(sr1),
		.sr2(sr2),
		.sr1_data(sr1_data),
		.sr2_data(sr2_data)
	);

	always_comb begin
		next.valid = instr_valid;
		next.pc = pc;
		next.ctrl = ctrl;
		next.sr1_data = sr1_data;
		next.sr2_data = sr2_data;
		next.imm_value = imm_value;
		next.dest = dest;
		next.opcode = lc3b_types::lc3b_opcode'(instruction[15:12]);
	end

	id_ex_register id_ex_register_inst (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.next(next),
		.id_ex(id_ex)
	);

endmodule : decode_stage

// ==== tb/decode_stage_table.svh ====
`ifndef DECODE_STAGE_TABLE_SVH
`define DECODE_STAGE_TABLE_SVH

// columns are valid, instruction, pc, expected imm_value, dest, sr1, sr2, then the control
// control is ctrl_of(alumux1, alumux2, alu, {indirect, read, write, mem_byte_sig, regfilemux},
// {load_regfile, memread, load_cc, destmux, pcmux_sel, pcmux_sel_out_sel})
task automatic fill_table();
	tests.push_back(make_test(1'b1, 16'h1283, 16'h3000, 16'h0000, 3'd1, 3'd2, 3'd3,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_add, 6'b000000, 7'b1010000)));
	tests.push_back(make_test(1'b1, 16'h197d, 16'h3002, 16'hfffd, 3'd4, 3'd5, 3'd5,
		ctrl_of(2'b00, 2'b11, lc3b_types::alu_add, 6'b000000, 7'b1010000)));
	tests.push_back(make_test(1'b1, 16'h5dc0, 16'h3004, 16'h0000, 3'd6, 3'd7, 3'd0,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_and, 6'b000000, 7'b1010000)));
	tests.push_back(make_test(1'b1, 16'h54ef, 16'h3006, 16'h000f, 3'd2, 3'd3, 3'd7,
		ctrl_of(2'b00, 2'b11, lc3b_types::alu_and, 6'b000000, 7'b1010000)));
	tests.push_back(make_test(1'b1, 16'h973f, 16'h3008, 16'h0000, 3'd3, 3'd4, 3'd7,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_not, 6'b000000, 7'b1010000)));
	tests.push_back(make_test(1'b1, 16'h62be, 16'h300a, 16'hfffc, 3'd1, 3'd2, 3'd6,
		ctrl_of(2'b00, 2'b01, lc3b_types::alu_add, 6'b010110, 7'b1110000)));
	tests.push_back(make_test(1'b1, 16'h2b85, 16'h300c, 16'h0005, 3'd5, 3'd6, 3'd5,
		ctrl_of(2'b00, 2'b01, lc3b_types::alu_add, 6'b010010, 7'b1110000)));
	tests.push_back(make_test(1'b1, 16'ha043, 16'h300e, 16'h0006, 3'd0, 3'd1, 3'd3,
		ctrl_of(2'b00, 2'b01, lc3b_types::alu_add, 6'b110000, 7'b1110000)));
	// stores take their second source from bits 11 to 9
	tests.push_back(make_test(1'b1, 16'h7707, 16'h3010, 16'h000e, 3'd3, 3'd4, 3'd3,
		ctrl_of(2'b00, 2'b01, lc3b_types::alu_add, 6'b001110, 7'b0000000)));
	tests.push_back(make_test(1'b1, 16'h3e20, 16'h3012, 16'hffe0, 3'd7, 3'd0, 3'd7,
		ctrl_of(2'b00, 2'b01, lc3b_types::alu_add, 6'b001010, 7'b0000000)));
	tests.push_back(make_test(1'b1, 16'hb57f, 16'h3014, 16'hfffe, 3'd2, 3'd5, 3'd2,
		ctrl_of(2'b00, 2'b01, lc3b_types::alu_add, 6'b101000, 7'b0000000)));
	tests.push_back(make_test(1'b1, 16'h0ffb, 16'h3016, 16'hfff6, 3'd7, 3'd7, 3'd3,
		ctrl_of(2'b01, 2'b10, lc3b_types::alu_add, 6'b000000, 7'b0000001)));
	tests.push_back(make_test(1'b1, 16'he840, 16'h3018, 16'h0080, 3'd4, 3'd1, 3'd0,
		ctrl_of(2'b00, 2'b10, lc3b_types::alu_add, 6'b000000, 7'b1010000)));
	tests.push_back(make_test(1'b1, 16'hc180, 16'h301a, 16'h0000, 3'd0, 3'd6, 3'd0,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_pass, 6'b000000, 7'b0000010)));
	tests.push_back(make_test(1'b1, 16'h4923, 16'h301c, 16'h0246, 3'd7, 3'd4, 3'd3,
		ctrl_of(2'b10, 2'b10, lc3b_types::alu_add, 6'b000001, 7'b1001010)));
	tests.push_back(make_test(1'b1, 16'h40c0, 16'h301e, 16'h0000, 3'd7, 3'd3, 3'd0,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_pass, 6'b000001, 7'b1001010)));
	tests.push_back(make_test(1'b1, 16'hd284, 16'h3020, 16'h0004, 3'd1, 3'd2, 3'd4,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_sll, 6'b000000, 7'b1010000)));
	tests.push_back(make_test(1'b1, 16'hd719, 16'h3022, 16'h0009, 3'd3, 3'd4, 3'd1,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_srl, 6'b000000, 7'b1010000)));
	tests.push_back(make_test(1'b1, 16'hdbbf, 16'h3024, 16'h000f, 3'd5, 3'd6, 3'd7,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_sra, 6'b000000, 7'b1010000)));
	tests.push_back(make_test(1'b1, 16'hf025, 16'h3026, 16'h004a, 3'd7, 3'd0, 3'd5,
		ctrl_of(2'b11, 2'b00, lc3b_types::alu_pass, 6'b000001, 7'b1001110)));
	tests.push_back(make_test(1'b1, 16'h8000, 16'h3028, 16'h0000, 3'd0, 3'd0, 3'd0,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_pass, 6'b000000, 7'b0000000)));
	// writeback lands on a source register in the same cycle as the read
	tests.push_back(make_test(1'b1, 16'h1485, 16'h302a, 16'h0000, 3'd2, 3'd2, 3'd5,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_add, 6'b000000, 7'b1010000)));
	with_writeback(3'd2, 16'hbeef);
	tests.push_back(make_test(1'b1, 16'h7c40, 16'h302c, 16'h0000, 3'd6, 3'd1, 3'd6,
		ctrl_of(2'b00, 2'b01, lc3b_types::alu_add, 6'b001110, 7'b0000000)));
	with_writeback(3'd6, 16'h1234);
	tests.push_back(make_test(1'b0, 16'h1283, 16'h302e, 16'h0000, 3'd1, 3'd2, 3'd3,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_add, 6'b000000, 7'b1010000)));
	tests.push_back(make_test(1'b1, 16'h1086, 16'h3030, 16'h0000, 3'd0, 3'd2, 3'd6,
		ctrl_of(2'b00, 2'b00, lc3b_types::alu_add, 6'b000000, 7'b1010000)));
endtask

`endif

// ==== tb/decode_stage_tb.sv ====
`timescale 1ns/10ps
`include "lc3b_defines.svh"

module decode_stage_tb;

	localparam int READY_TIMEOUT = 20;

	typedef struct packed {
		logic valid;
		lc3b_types::lc3b_word instruction;
		lc3b_types::lc3b_word pc;
		lc3b_types::lc3b_word imm;
		lc3b_types::lc3b_reg dest;
		lc3b_types::lc3b_reg sr1;
		lc3b_types::lc3b_reg sr2;
		lc3b_types::lc3b_ctrl_t ctrl;
		logic wb_en;
		lc3b_types::lc3b_reg wb_dest;
		lc3b_types::lc3b_word wb_data;
	} test_entry_t;

	logic clk;
	logic reset;
	logic instr_valid;
	lc3b_types::lc3b_word instruction;
	lc3b_types::lc3b_word pc;
	logic stall;
	logic wb_en;
	lc3b_types::lc3b_reg wb_dest;
	lc3b_types::lc3b_word wb_data;
	logic ready;
	lc3b_types::lc3b_id_ex_t id_ex;

	test_entry_t tests[$];
	lc3b_types::lc3b_word reg_copy [`LC3B_NUM_REGS];
	integer seed;
	int test_count;
	int failed_tests;
	int error_count;
	bit timed_out;

	decode_stage decode_stage_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic lc3b_types::lc3b_ctrl_t ctrl_of(input logic [1:0] mux1,
			input logic [1:0] mux2, input lc3b_types::lc3b_aluop alu,
			input logic [5:0] mem, input logic [6:0] wb);
		return {mux1, mux2, alu, mem, wb};
	endfunction

	function automatic test_entry_t make_test(input logic valid, input lc3b_types::lc3b_word instr,
			input lc3b_types::lc3b_word pc_value, input lc3b_types::lc3b_word imm,
			input lc3b_types::lc3b_reg dest, input lc3b_types::lc3b_reg sr1,
			input lc3b_types::lc3b_reg sr2, input lc3b_types::lc3b_ctrl_t ctrl);
		return {valid, instr, pc_value, imm, dest, sr1, sr2, ctrl, 1'b0, 3'd0, 16'h0000};
	endfunction

	task automatic with_writeback(input lc3b_types::lc3b_reg dest, input lc3b_types::lc3b_word data);
		test_entry_t t;
		t = tests.pop_back();
		t.wb_en = 1'b1;
		t.wb_dest = dest;
		t.wb_data = data;
		tests.push_back(t);
	endtask

	`include "decode_stage_table.svh"

	task automatic next_edge();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!ready && cycles < READY_TIMEOUT) begin
			next_edge();
			cycles++;
		end
		if (!ready) begin
			$display("timeout: DUT did not raise ready within %0d cycles", READY_TIMEOUT);
			error_count++;
			timed_out = 1'b1;
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected)
		else begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_bundle(input test_entry_t t, input lc3b_types::lc3b_word exp_sr1,
			input lc3b_types::lc3b_word exp_sr2);
		check_value("id_ex.valid", 32'(id_ex.valid), 32'(t.valid));
		if (t.valid) begin
			check_value("id_ex.pc", 32'(id_ex.pc), 32'(t.pc));
			check_value("id_ex.ctrl", 32'(id_ex.ctrl), 32'(t.ctrl));
			check_value("id_ex.sr1_data", 32'(id_ex.sr1_data), 32'(exp_sr1));
			check_value("id_ex.sr2_data", 32'(id_ex.sr2_data), 32'(exp_sr2));
			check_value("id_ex.imm_value", 32'(id_ex.imm_value), 32'(t.imm));
			check_value("id_ex.dest", 32'(id_ex.dest), 32'(t.dest));
			check_value("id_ex.opcode", 32'(id_ex.opcode), 32'(t.instruction[15:12]));
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			$display("test %0d %s passed", test_count, name);
		end else begin
			failed_tests++;
			$display("test %0d %s failed", test_count, name);
		end
	endtask

	task automatic run_test(input test_entry_t t, output lc3b_types::lc3b_word exp_sr1,
			output lc3b_types::lc3b_word exp_sr2);
		lc3b_types::lc3b_opcode op;
		string name;
		int errors_before;
		errors_before = error_count;
		op = lc3b_types::lc3b_opcode'(t.instruction[15:12]);
		name = t.valid ? op.name() : "bubble";
		wait_ready();
		if (!timed_out) begin
			instr_valid = t.valid;
			instruction = t.instruction;
			pc = t.pc;
			wb_en = t.wb_en;
			wb_dest = t.wb_dest;
			wb_data = t.wb_data;
			// the write lands on this edge and a read of the same cycle already sees it
			if (t.wb_en)
				reg_copy[t.wb_dest] = t.wb_data;
			exp_sr1 = reg_copy[t.sr1];
			exp_sr2 = reg_copy[t.sr2];
			next_edge();
			wb_en = 1'b0;
			check_bundle(t, exp_sr1, exp_sr2);
			report_test(name, errors_before);
		end
	endtask

	initial begin
		test_entry_t held;
		lc3b_types::lc3b_word held_sr1;
		lc3b_types::lc3b_word held_sr2;
		lc3b_types::lc3b_word scratch_sr1;
		lc3b_types::lc3b_word scratch_sr2;
		lc3b_types::lc3b_word data;
		int errors_before;
		seed = 32'h03c84574;
		reset = 1'b1;
		// fetch presents an instruction during reset, only reset keeps id_ex empty
		instr_valid = 1'b1;
		instruction = '0;
		pc = '0;
		stall = 1'b0;
		wb_en = 1'b0;
		wb_dest = '0;
		wb_data = '0;
		test_count = 0;
		failed_tests = 0;
		error_count = 0;
		timed_out = 1'b0;
		for (int r = 0; r < `LC3B_NUM_REGS; r++)
			reg_copy[r] = '0;
		fill_table();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		errors_before = error_count;
		check_value("id_ex.valid", 32'(id_ex.valid), 32'(1'b0));
		report_test("reset", errors_before);

		// ADD R0, Rn, Rn sees each register still cleared
		for (int r = 0; r < `LC3B_NUM_REGS; r++) begin
			if (!timed_out)
				run_test(make_test(1'b1, {4'b0001, 3'd0, 3'(r), 3'b000, 3'(r)}, 16'h2000,
					16'h0000, 3'd0, 3'(r), 3'(r),
					ctrl_of(2'b00, 2'b00, lc3b_types::alu_add, 6'b000000, 7'b1010000)),
					scratch_sr1, scratch_sr2);
		end

		for (int r = 0; r < `LC3B_NUM_REGS; r++) begin
			data = 16'($random(seed));
			wb_en = 1'b1;
			wb_dest = 3'(r);
			wb_data = data;
			next_edge();
			reg_copy[r] = data;
		end
		wb_en = 1'b0;

		foreach (tests[i]) begin
			if (!timed_out)
				run_test(tests[i], scratch_sr1, scratch_sr2);
		end

		// a store goes in, then three stalled edges must leave it in place
		held = make_test(1'b1, 16'h7707, 16'h3100, 16'h000e, 3'd3, 3'd4, 3'd3,
			ctrl_of(2'b00, 2'b01, lc3b_types::alu_add, 6'b001110, 7'b0000000));
		if (!timed_out)
			run_test(held, held_sr1, held_sr2);
		if (!timed_out) begin
			errors_before = error_count;
			stall = 1'b1;
			instr_valid = 1'b1;
			instruction = 16'h1283;
			pc = 16'h3102;
			for (int i = 0; i < 3; i++) begin
				next_edge();
				check_value("ready", 32'(ready), 32'(1'b0));
				check_bundle(held, held_sr1, held_sr2);
			end
			report_test("stall", errors_before);
			stall = 1'b0;
			instr_valid = 1'b0;
		end

		$display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule : decode_stage_tb

// ==== list.f ====
+incdir+source
+incdir+tb
source/lc3b_types.sv
source/decode.sv
source/regfile.sv
source/operand_select.sv
source/id_ex_register.sv
source/decode_stage.sv
tb/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: lc3b_decode_stage

sources:
  - include_dirs:
      - source
    files:
      - source/lc3b_types.sv
      - source/decode.sv
      - source/regfile.sv
      - source/operand_select.sv
      - source/id_ex_register.sv
      - source/decode_stage.sv
  - target: test
    include_dirs:
      - source
      - tb
    files:
      - tb/decode_stage_tb.sv
